/* filelist.f */
hdl/exu_pkg.sv
hdl/exu_alu.sv
hdl/exu_ctrl.sv
hdl/exu_regfile.sv
hdl/exu_muldiv.sv
hdl/exu_lsu.sv
hdl/exu_top.sv
verif/exu_tb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing -j 0 -Wno-fatal
TOP      = exu_tb
FILELIST = filelist.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verif/exu_tb.sv */
`timescale 1ns/1ns

module exu_tb import exu_pkg::*; ();

    typedef struct packed {
        exu_op_u              op;
        logic [reg_idx_w-1:0] rd;
        logic [reg_idx_w-1:0] rs1;
        logic [reg_idx_w-1:0] rs2;
        logic [xlen-1:0]      imm;
        logic [xlen-1:0]      pc;
        logic                 en;
        logic [xlen-1:0]      data;
        logic [xlen-1:0]      npc;
    } entry_t;

    logic                 clk;
    logic                 arst_n;
    exu_op_u              op;
    logic [reg_idx_w-1:0] rd;
    logic [reg_idx_w-1:0] rs1;
    logic [reg_idx_w-1:0] rs2;
    logic [xlen-1:0]      imm;
    logic [xlen-1:0]      pc;
    logic [xlen-1:0]      dnpc;
    logic                 wb_en;
    logic [xlen-1:0]      wb_data;
    logic                 halt;
    logic                 halt_code;

    entry_t          tests[$];
    logic [xlen-1:0] next_pc;
    integer          seed;

    exu_top u_dut (
        .clk(clk), .arst_n(arst_n), .op(op), .rd(rd), .rs1(rs1), .rs2(rs2),
        .imm(imm), .pc(pc), .dnpc(dnpc), .wb_en(wb_en), .wb_data(wb_data),
        .halt(halt), .halt_code(halt_code)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10;
            clk = ~clk;
        end
    end

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Test failures found");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_data(input string name, input logic [xlen-1:0] got,
                              input logic [xlen-1:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("CHECK FAILED at %0t ns: %s got %h expected %h",
                                    $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("CHECK FAILED at %0t ns: %s got %b expected %b",
                                    $time, name, got, exp));
        end
    endtask

    task automatic check_op_result(input entry_t e);
        op_e   code;
        string tag;
        code = e.op.code;
        tag  = $sformatf("%s at pc %h", code.name(), e.pc);
        check_bit({"wb_en for ", tag}, wb_en, e.en);
        if (e.en) begin
            check_data({"wb_data for ", tag}, wb_data, e.data);
        end
        check_data({"dnpc for ", tag}, dnpc, e.npc);
    endtask

    // reference results for the random pass
    function automatic logic [xlen-1:0] expected_result(input op_e code,
            input logic [xlen-1:0] a, input logic [xlen-1:0] b);
        logic [31:0] w;
        case (code)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_xor:  return a ^ b;
            op_sltu: return {63'b0, a < b};
            op_addw: begin
                w = a[31:0] + b[31:0];
                return {{32{w[31]}}, w};
            end
            op_mul:  return a * b;
            op_divu: return (b == '0) ? '1 : a / b;
            op_remu: return (b == '0) ? a : a % b;
            default: return '0;
        endcase
    endfunction

    function automatic entry_t make_entry(input op_e code, input logic [4:0] d, s1, s2,
            input logic [xlen-1:0] i, p, input logic en, input logic [xlen-1:0] data, npc);
        entry_t e;
        e.op.code = code;
        e.rd      = d;
        e.rs1     = s1;
        e.rs2     = s2;
        e.imm     = i;
        e.pc      = p;
        e.en      = en;
        e.data    = data;
        e.npc     = npc;
        return e;
    endfunction

    // straight-line entry, falls through to pc+4
    function automatic entry_t seq_entry(input op_e code, input logic [4:0] d, s1, s2,
            input logic [xlen-1:0] i, input logic en, input logic [xlen-1:0] data);
        entry_t e;
        e       = make_entry(code, d, s1, s2, i, next_pc, en, data, next_pc + 64'd4);
        next_pc = next_pc + 64'd4;
        return e;
    endfunction

    task automatic push_seq(input op_e code, input logic [4:0] d, s1, s2,
            input logic [xlen-1:0] i, input logic en, input logic [xlen-1:0] data);
        tests.push_back(seq_entry(code, d, s1, s2, i, en, data));
    endtask

    task automatic push_flow(input op_e code, input logic [4:0] d, s1, s2,
            input logic [xlen-1:0] i, p, input logic en, input logic [xlen-1:0] data, npc);
        tests.push_back(make_entry(code, d, s1, s2, i, p, en, data, npc));
    endtask

    task automatic apply(input entry_t e);
        @(posedge clk);
        #2;
        op  = e.op;
        rd  = e.rd;
        rs1 = e.rs1;
        rs2 = e.rs2;
        imm = e.imm;
        pc  = e.pc;
        // sample just before the next edge
        #17;
    endtask

    task automatic run_seq(input op_e code, input logic [4:0] d, s1, s2,
            input logic [xlen-1:0] i, input logic en, input logic [xlen-1:0] data);
        entry_t e;
        e = seq_entry(code, d, s1, s2, i, en, data);
        apply(e);
        check_op_result(e);
    endtask

    task automatic build_tests();
        op_e             ops[8];
        logic [xlen-1:0] ra;
        logic [xlen-1:0] rb;
        next_pc = 64'h8000_0000;
        // registers and memory come out of reset as zero
        push_seq(op_add,   1, 7, 8, '0, 1, '0);
        push_seq(op_ld,    1, 0, 0, 64'h80, 1, '0);
        push_seq(op_addi,  1, 0, 0, 64'd5, 1, 64'd5);
        push_seq(op_addi,  2, 0, 0, -64'sd3, 1, -64'sd3);
        push_seq(op_add,   3, 1, 2, '0, 1, 64'd2);
        push_seq(op_sub,   4, 1, 2, '0, 1, 64'd8);
        push_seq(op_sltu,  5, 1, 2, '0, 1, 64'd1);
        push_seq(op_slt,   6, 1, 2, '0, 1, 64'd0);
        push_seq(op_sltu,  7, 2, 1, '0, 1, 64'd0);
        push_seq(op_slti,  7, 2, 0, 64'd1, 1, 64'd1);
        push_seq(op_addi,  8, 0, 0, 64'h8000_0000, 1, 64'h8000_0000);
        push_seq(op_sraw,  9, 8, 1, '0, 1, 64'hffff_ffff_fc00_0000);
        push_seq(op_srlw, 11, 8, 1, '0, 1, 64'h0400_0000);
        push_seq(op_srl,  12, 2, 1, '0, 1, 64'h07ff_ffff_ffff_ffff);
        push_seq(op_sra,  13, 2, 1, '0, 1, '1);
        push_seq(op_sll,  14, 1, 1, '0, 1, 64'ha0);
        push_seq(op_addw, 15, 8, 8, '0, 1, '0);
        push_seq(op_subw, 16, 0, 8, '0, 1, 64'hffff_ffff_8000_0000);
        push_seq(op_and,  17, 1, 2, '0, 1, 64'd5);
        push_seq(op_or,   18, 1, 2, '0, 1, -64'sd3);
        push_seq(op_xor,  19, 1, 2, '0, 1, -64'sd8);
        push_seq(op_slliw, 20, 1, 0, 64'd30, 1, 64'h4000_0000);
        // x0 ignores the write
        push_seq(op_addi,  0, 0, 0, 64'd7, 1, 64'd7);
        push_seq(op_add,  21, 0, 0, '0, 1, '0);
        push_seq(op_mul,  22, 2, 1, '0, 1, -64'sd15);
        push_seq(op_mulw, 23, 8, 1, '0, 1, 64'hffff_ffff_8000_0000);
        push_seq(op_divu, 24, 1, 0, '0, 1, '1);
        push_seq(op_remu, 25, 1, 0, '0, 1, 64'd5);
        push_seq(op_divu, 26, 2, 1, '0, 1, 64'h3333_3333_3333_3332);
        push_seq(op_remu, 27, 2, 1, '0, 1, 64'd3);
        push_seq(op_divw, 28, 8, 13, '0, 1, 64'hffff_ffff_8000_0000);
        push_seq(op_remw, 29, 8, 13, '0, 1, '0);
        push_seq(op_divw, 30, 2, 0, '0, 1, '1);
        push_seq(op_remw, 31, 2, 0, '0, 1, -64'sd3);
        push_seq(op_divw, 30, 2, 1, '0, 1, '0);
        push_seq(op_remw, 31, 2, 1, '0, 1, -64'sd3);
        // stores, then loads of every width
        push_seq(op_addi, 20, 0, 0, 64'h1122_3344_5566_7788, 1, 64'h1122_3344_5566_7788);
        push_seq(op_addi,  9, 0, 0, 64'hdead_beef_cafe_f0aa, 1, 64'hdead_beef_cafe_f0aa);
        push_seq(op_sd,    0, 0, 20, 64'h10, 0, '0);
        push_seq(op_ld,   21, 0, 0, 64'h10, 1, 64'h1122_3344_5566_7788);
        push_seq(op_sb,    0, 0, 9, 64'h13, 0, '0);
        push_seq(op_sh,    0, 0, 9, 64'h16, 0, '0);
        push_seq(op_sw,    0, 0, 9, 64'h18, 0, '0);
        push_seq(op_sb,    0, 1, 9, 64'h20, 0, '0);
        push_seq(op_ld,   21, 0, 0, 64'h10, 1, 64'hf0aa_3344_aa66_7788);
        push_seq(op_lb,   21, 0, 0, 64'h13, 1, 64'hffff_ffff_ffff_ffaa);
        push_seq(op_lbu,  21, 0, 0, 64'h13, 1, 64'haa);
        push_seq(op_lb,   21, 0, 0, 64'h11, 1, 64'h77);
        push_seq(op_lh,   21, 0, 0, 64'h16, 1, 64'hffff_ffff_ffff_f0aa);
        push_seq(op_lhu,  21, 0, 0, 64'h16, 1, 64'hf0aa);
        push_seq(op_lh,   21, 0, 0, 64'h12, 1, 64'hffff_ffff_ffff_aa66);
        push_seq(op_lw,   21, 0, 0, 64'h14, 1, 64'hffff_ffff_f0aa_3344);
        push_seq(op_lwu,  21, 0, 0, 64'h14, 1, 64'hf0aa_3344);
        push_seq(op_lw,   21, 0, 0, 64'h18, 1, 64'hffff_ffff_cafe_f0aa);
        push_seq(op_ld,   21, 0, 0, 64'h18, 1, 64'hcafe_f0aa);
        push_seq(op_ld,   21, 0, 0, 64'h20, 1, 64'h0000_aa00_0000_0000);
        // branches taken and not taken, x1 = 5 and x2 = -3
        push_flow(op_beq,  0, 1, 1, 64'h40, 64'h8000_1000, 0, '0, 64'h8000_1040);
        push_flow(op_beq,  0, 1, 2, 64'h40, 64'h8000_1010, 0, '0, 64'h8000_1014);
        push_flow(op_bne,  0, 1, 2, 64'h40, 64'h8000_1020, 0, '0, 64'h8000_1060);
        push_flow(op_bne,  0, 1, 1, 64'h40, 64'h8000_1030, 0, '0, 64'h8000_1034);
        push_flow(op_blt,  0, 2, 1, -64'sd16, 64'h8000_1040, 0, '0, 64'h8000_1030);
        push_flow(op_blt,  0, 1, 2, -64'sd16, 64'h8000_1050, 0, '0, 64'h8000_1054);
        push_flow(op_bge,  0, 1, 2, 64'h40, 64'h8000_1060, 0, '0, 64'h8000_10a0);
        push_flow(op_bge,  0, 2, 1, 64'h40, 64'h8000_1070, 0, '0, 64'h8000_1074);
        push_flow(op_bltu, 0, 1, 2, 64'h40, 64'h8000_1080, 0, '0, 64'h8000_10c0);
        push_flow(op_bltu, 0, 2, 1, 64'h40, 64'h8000_1090, 0, '0, 64'h8000_1094);
        push_flow(op_bgeu, 0, 2, 1, 64'h40, 64'h8000_10a0, 0, '0, 64'h8000_10e0);
        push_flow(op_bgeu, 0, 1, 2, 64'h40, 64'h8000_10b0, 0, '0, 64'h8000_10b4);
        push_flow(op_jal,  3, 0, 0, 64'h100, 64'h8000_2000, 1, 64'h8000_2004, 64'h8000_2100);
        // jalr target 0x2005 loses bit 0
        push_flow(op_jalr, 4, 1, 0, 64'h2000, 64'h8000_3000, 1, 64'h8000_3004, 64'h2004);
        push_seq(op_lui,   5, 0, 0, 64'hffff_ffff_8765_4000, 1, 64'hffff_ffff_8765_4000);
        push_flow(op_auipc, 6, 0, 0, 64'h1000, 64'h8000_5000, 1, 64'h8000_6000, 64'h8000_5004);
        // random operands, first pass divides by zero
        ops = '{op_add, op_sub, op_xor, op_sltu, op_addw, op_mul, op_divu, op_remu};
        for (int n = 0; n < 6; n++) begin
            ra = {$random(seed), $random(seed)};
            rb = (n == 0) ? '0 : {$random(seed), $random(seed)};
            push_seq(op_addi, 1, 0, 0, ra, 1, ra);
            push_seq(op_addi, 2, 0, 0, rb, 1, rb);
            foreach (ops[k]) begin
                push_seq(ops[k], 3, 1, 2, '0, 1, expected_result(ops[k], ra, rb));
            end
        end
    endtask

    initial begin
        int edges;
        op     = '0;
        rd     = '0;
        rs1    = '0;
        rs2    = '0;
        imm    = '0;
        pc     = '0;
        arst_n = 1'b0;
        seed   = 32'hd430_5473;
        build_tests();
        repeat (5) @(posedge clk);
        #2;
        arst_n = 1'b1;
        check_bit("halt after reset", halt, 1'b0);
        check_bit("halt_code after reset", halt_code, 1'b0);
        foreach (tests[n]) begin
            apply(tests[n]);
            check_op_result(tests[n]);
            check_bit("halt before ebreak", halt, 1'b0);
        end
        // ebreak with a0 nonzero
        run_seq(op_addi, 10, 0, 0, 64'd1, 1, 64'd1);
        run_seq(op_ebreak, 0, 0, 0, '0, 0, '0);
        check_bit("halt in ebreak cycle", halt, 1'b0);
        for (edges = 0; edges < 8 && halt !== 1'b1; edges++) begin
            @(posedge clk);
            #1;
        end
        if (halt !== 1'b1) begin
            stop_on_error("halt never rose after ebreak");
        end
        if (edges != 1) begin
            stop_on_error($sformatf("halt rose %0d edges after ebreak instead of 1", edges));
        end
        check_bit("halt_code", halt_code, 1'b1);
        // halted core must not write registers or memory
        run_seq(op_addi, 11, 0, 0, 64'h55, 0, '0);
        run_seq(op_sd, 0, 0, 9, 64'h80, 0, '0);
        run_seq(op_add, 12, 11, 0, '0, 0, '0);
        check_data("x11 after halted write", wb_data, 64'h0400_0000);
        run_seq(op_ld, 12, 0, 0, 64'h80, 0, '0);
        check_data("memory after halted store", wb_data, '0);
        check_bit("halt stays high", halt, 1'b1);
        $display("All tests passed!");
        $finish;
    end

endmodule

/* hdl/exu_top.sv */
`timescale 1ns/1ns

module exu_top import exu_pkg::*; (
    input  logic                 clk,
    input  logic                 arst_n,
    input  exu_op_u              op,
    input  logic [reg_idx_w-1:0] rd,
    input  logic [reg_idx_w-1:0] rs1,
    input  logic [reg_idx_w-1:0] rs2,
    input  logic [xlen-1:0]      imm,
    input  logic [xlen-1:0]      pc,
    output logic [xlen-1:0]      dnpc,
    output logic                 wb_en,
    output logic [xlen-1:0]      wb_data,
    output logic                 halt,
    output logic                 halt_code
);

    logic            a_sel_pc;
    alu_src_e        b_sel;
    logic            mem_rd;
    logic            mem_wr;
    logic [2:0]      wb_sel;
    logic            halt_set;
    logic [xlen-1:0] src1;
    logic [xlen-1:0] src2;
    logic [xlen-1:0] a0;
    logic [xlen-1:0] alu_a;
    logic [xlen-1:0] alu_b;
    logic [4:0]      alu_func;
    logic            alu_word;
    logic [xlen-1:0] alu_result;
    logic            branch_taken;
    logic [xlen-1:0] md_result;
    logic [xlen-1:0] load_data;

    exu_ctrl u_ctrl (
        .op(op), .pc(pc), .imm(imm), .alu_result(alu_result),
        .branch_taken(branch_taken), .halt(halt), .wb_en(wb_en),
        .a_sel_pc(a_sel_pc), .b_sel(b_sel), .mem_rd(mem_rd), .mem_wr(mem_wr),
        .wb_sel(wb_sel), .dnpc(dnpc), .halt_set(halt_set)
    );

    exu_regfile u_regfile (
        .clk(clk), .arst_n(arst_n), .we(wb_en), .waddr(rd), .wdata(wb_data),
        .raddr1(rs1), .raddr2(rs2), .rdata1(src1), .rdata2(src2), .a0(a0)
    );

    // other units borrow the adder
    assign alu_func = (op.f.unit == unit_alu || op.f.unit == unit_branch) ? op.f.func : 5'd0;
    assign alu_word = (op.f.unit == unit_alu) && (op.f.func[3:0] > 4'd9);
    assign alu_a    = a_sel_pc ? pc : src1;

    always_comb begin
        case (b_sel)
            src_imm:  alu_b = imm;
            src_four: alu_b = 64'd4;
            default:  alu_b = src2;
        endcase
    end

    exu_alu u_alu (
        .func(alu_func), .word(alu_word), .a(alu_a), .b(alu_b),
        .result(alu_result), .branch_taken(branch_taken)
    );

    exu_muldiv u_muldiv (.func(op.f.func), .a(src1), .b(src2), .result(md_result));

    exu_lsu u_lsu (
        .clk(clk), .arst_n(arst_n), .func(op.f.func), .rd_en(mem_rd), .wr_en(mem_wr),
        .addr(alu_result), .wdata(src2), .rdata(load_data)
    );

    always_comb begin
        case (wb_sel)
            wb_md:   wb_data = md_result;
            wb_load: wb_data = load_data;
            wb_imm:  wb_data = imm;
            wb_pc4:  wb_data = pc + 64'd4;
            default: wb_data = alu_result;
        endcase
    end

    // sticky until reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            halt      <= 1'b0;
            halt_code <= 1'b0;
        end else if (halt_set) begin
            halt      <= 1'b1;
            halt_code <= a0 != '0;
        end
    end

endmodule

/* hdl/exu_lsu.sv */
`timescale 1ns/1ns

module exu_lsu import exu_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    input  logic [4:0]      func,
    input  logic            rd_en,
    input  logic            wr_en,
    input  logic [xlen-1:0] addr,
    input  logic [xlen-1:0] wdata,
    output logic [xlen-1:0] rdata
);

    logic [xlen-1:0] mem [mem_words];
    logic [4:0]      idx;
    logic [2:0]      ofs;
    logic [7:0]      size_mask;
    logic [7:0]      byte_mask;
    logic [xlen-1:0] bit_mask;
    logic [xlen-1:0] wshift;
    logic [xlen-1:0] lane;
    logic [xlen-1:0] ext;

    assign idx = addr[7:3];
    assign ofs = addr[2:0];

    always_comb begin
        case (func[1:0])
            2'd0:    size_mask = 8'h01;
            2'd1:    size_mask = 8'h03;
            2'd2:    size_mask = 8'h0f;
            default: size_mask = 8'hff;
        endcase
    end

    // halfwords and words are naturally aligned so nothing spills over
    assign byte_mask = size_mask << ofs;
    assign wshift    = wdata << {ofs, 3'b000};

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            bit_mask[8*i +: 8] = {8{byte_mask[i]}};
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < mem_words; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en) begin
            mem[idx] <= (mem[idx] & ~bit_mask) | (wshift & bit_mask);
        end
    end

    // addressed byte moved down to lane 0
    assign lane = mem[idx] >> {ofs, 3'b000};

    always_comb begin
        case (func[2:0])
            3'd0:    ext = {{56{lane[7]}}, lane[7:0]};
            3'd1:    ext = {{48{lane[15]}}, lane[15:0]};
            3'd2:    ext = {{32{lane[31]}}, lane[31:0]};
            3'd4:    ext = {56'b0, lane[7:0]};
            3'd5:    ext = {48'b0, lane[15:0]};
            3'd6:    ext = {32'b0, lane[31:0]};
            default: ext = lane;
        endcase
    end

    assign rdata = rd_en ? ext : '0;

endmodule

/* hdl/exu_muldiv.sv */
`timescale 1ns/1ns

module exu_muldiv import exu_pkg::*; (
    input  logic [4:0]      func,
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    output logic [xlen-1:0] result
);

    logic [31:0]     a_w;
    logic [31:0]     b_w;
    logic [31:0]     mul_w;
    logic [31:0]     q_w;
    logic [31:0]     r_w;
    logic [xlen-1:0] q_u;
    logic [xlen-1:0] r_u;

    assign a_w   = a[31:0];
    assign b_w   = b[31:0];
    assign mul_w = a_w * b_w;

    // divide by zero and overflow follow the riscv spec
    always_comb begin
        if (b_w == '0) begin
            q_w = '1;
            r_w = a_w;
        end else if (a_w == 32'h8000_0000 && b_w == '1) begin
            q_w = a_w;
            r_w = '0;
        end else begin
            q_w = $signed(a_w) / $signed(b_w);
            r_w = $signed(a_w) % $signed(b_w);
        end
    end

    assign q_u = (b == '0) ? '1 : a / b;
    assign r_u = (b == '0) ? a : a % b;

    always_comb begin
        case (func)
            5'd0:    result = a * b;
            5'd1:    result = q_u;
            5'd2:    result = r_u;
            5'd16:   result = {{32{mul_w[31]}}, mul_w};
            5'd17:   result = {{32{q_w[31]}}, q_w};
            5'd18:   result = {{32{r_w[31]}}, r_w};
            default: result = '0;
        endcase
    end

endmodule

/* hdl/exu_regfile.sv */
`timescale 1ns/1ns

module exu_regfile import exu_pkg::*; (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 we,
    input  logic [reg_idx_w-1:0] waddr,
    input  logic [xlen-1:0]      wdata,
    input  logic [reg_idx_w-1:0] raddr1,
    input  logic [reg_idx_w-1:0] raddr2,
    output logic [xlen-1:0]      rdata1,
    output logic [xlen-1:0]      rdata2,
    output logic [xlen-1:0]      a0
);

    // x0 has no storage
    logic [xlen-1:0] regs [1:31];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];
    assign a0     = regs[10];

endmodule

/* hdl/exu_ctrl.sv */
`timescale 1ns/1ns

module exu_ctrl import exu_pkg::*; (
    input  exu_op_u         op,
    input  logic [xlen-1:0] pc,
    input  logic [xlen-1:0] imm,
    input  logic [xlen-1:0] alu_result,
    input  logic            branch_taken,
    input  logic            halt,
    output logic            wb_en,
    output logic            a_sel_pc,
    output alu_src_e        b_sel,
    output logic            mem_rd,
    output logic            mem_wr,
    output logic [2:0]      wb_sel,
    output logic [xlen-1:0] dnpc,
    output logic            halt_set
);

    logic [xlen-1:0] snpc;
    logic [xlen-1:0] target;

    assign snpc   = pc + 64'd4;
    assign target = pc + imm;

    always_comb begin
        wb_en    = 1'b0;
        a_sel_pc = 1'b0;
        b_sel    = src_reg;
        mem_rd   = 1'b0;
        mem_wr   = 1'b0;
        wb_sel   = wb_alu;
        halt_set = 1'b0;
        dnpc     = snpc;
        case (op.code)
            op_add, op_sub, op_sll, op_srl, op_sra, op_slt, op_sltu, op_and, op_or,
            op_xor, op_addw, op_subw, op_sllw, op_srlw, op_sraw: begin
                wb_en = 1'b1;
            end
            op_addi, op_slli, op_srli, op_srai, op_slti, op_sltiu, op_andi, op_ori,
            op_xori, op_addiw, op_slliw, op_srliw, op_sraiw: begin
                wb_en = 1'b1;
                b_sel = src_imm;
            end
            op_mul, op_divu, op_remu, op_mulw, op_divw, op_remw: begin
                wb_en  = 1'b1;
                wb_sel = wb_md;
            end
            op_lb, op_lh, op_lw, op_ld, op_lbu, op_lhu, op_lwu: begin
                wb_en  = 1'b1;
                b_sel  = src_imm;
                mem_rd = 1'b1;
                wb_sel = wb_load;
            end
            op_sb, op_sh, op_sw, op_sd: begin
                b_sel  = src_imm;
                mem_wr = 1'b1;
            end
            op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu: begin
                dnpc = branch_taken ? target : snpc;
            end
            op_jal: begin
                // link address pc+4 comes out of the alu
                wb_en    = 1'b1;
                a_sel_pc = 1'b1;
                b_sel    = src_four;
                dnpc     = target;
            end
            op_jalr: begin
                wb_en  = 1'b1;
                b_sel  = src_imm;
                wb_sel = wb_pc4;
                dnpc   = {alu_result[xlen-1:1], 1'b0};
            end
            op_lui: begin
                wb_en  = 1'b1;
                wb_sel = wb_imm;
            end
            op_auipc: begin
                wb_en    = 1'b1;
                a_sel_pc = 1'b1;
                b_sel    = src_imm;
            end
            op_ebreak: halt_set = !halt;
            default: ;
        endcase
        // core is frozen once halted
        if (halt) begin
            wb_en  = 1'b0;
            mem_wr = 1'b0;
        end
    end

endmodule

/* hdl/exu_alu.sv */
`timescale 1ns/1ns

module exu_alu import exu_pkg::*; (
    input  logic [4:0]      func,
    input  logic            word,
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    output logic [xlen-1:0] result,
    output logic            branch_taken
);

    logic [5:0]      shamt;
    logic            eq;
    logic            lt;
    logic            ltu;
    logic [xlen-1:0] res;

    assign shamt = word ? {1'b0, b[4:0]} : b[5:0];
    assign eq    = a == b;
    assign lt    = $signed(a) < $signed(b);
    assign ltu   = a < b;

    always_comb begin
        res = '0;
        case (func[3:0])
            4'd0, 4'd10: res = a + b;
            4'd1, 4'd11: res = a - b;
            4'd2, 4'd12: res = a << shamt;
            // word right shifts start from the low word
            4'd3, 4'd13: res = (word ? {32'b0, a[31:0]} : a) >> shamt;
            4'd4, 4'd14: res = $signed(word ? {{32{a[31]}}, a[31:0]} : a) >>> shamt;
            4'd5:        res = {63'b0, lt};
            4'd6:        res = {63'b0, ltu};
            4'd7:        res = a & b;
            4'd8:        res = a | b;
            4'd9:        res = a ^ b;
            default:     res = '0;
        endcase
    end

    assign result = word ? {{32{res[31]}}, res[31:0]} : res;

    // funct3 style branch conditions
    always_comb begin
        case (func)
            5'd0:    branch_taken = eq;
            5'd1:    branch_taken = !eq;
            5'd4:    branch_taken = lt;
            5'd5:    branch_taken = !lt;
            5'd6:    branch_taken = ltu;
            5'd7:    branch_taken = !ltu;
            default: branch_taken = 1'b0;
        endcase
    end

endmodule

/* hdl/exu_pkg.sv */
package exu_pkg;

    localparam int xlen      = 64;
    localparam int reg_idx_w = 5;
    localparam int mem_words = 32;

    // writeback source codes
    localparam logic [2:0] wb_alu  = 3'd0;
    localparam logic [2:0] wb_md   = 3'd1;
    localparam logic [2:0] wb_load = 3'd2;
    localparam logic [2:0] wb_imm  = 3'd3;
    localparam logic [2:0] wb_pc4  = 3'd4;

    typedef enum logic [2:0] {
        unit_alu    = 3'd0,
        unit_muldiv = 3'd1,
        unit_load   = 3'd2,
        unit_store  = 3'd3,
        unit_branch = 3'd4,
        unit_jump   = 3'd5,
        unit_upper  = 3'd6,
        unit_sys    = 3'd7
    } unit_e;

    // alu func: bit 4 marks an immediate operand, 10..14 are the word forms
    // load func: bits 1:0 size, bit 2 zero extension
    // branch func follows funct3
    typedef enum logic [7:0] {
        op_add   = 8'h00, op_sub   = 8'h01, op_sll   = 8'h02, op_srl   = 8'h03,
        op_sra   = 8'h04, op_slt   = 8'h05, op_sltu  = 8'h06, op_and   = 8'h07,
        op_or    = 8'h08, op_xor   = 8'h09, op_addw  = 8'h0a, op_subw  = 8'h0b,
        op_sllw  = 8'h0c, op_srlw  = 8'h0d, op_sraw  = 8'h0e,
        op_addi  = 8'h10, op_slli  = 8'h12, op_srli  = 8'h13, op_srai  = 8'h14,
        op_slti  = 8'h15, op_sltiu = 8'h16, op_andi  = 8'h17, op_ori   = 8'h18,
        op_xori  = 8'h19, op_addiw = 8'h1a, op_slliw = 8'h1c, op_srliw = 8'h1d,
        op_sraiw = 8'h1e,
        op_mul   = 8'h20, op_divu  = 8'h21, op_remu  = 8'h22,
        op_mulw  = 8'h30, op_divw  = 8'h31, op_remw  = 8'h32,
        op_lb    = 8'h40, op_lh    = 8'h41, op_lw    = 8'h42, op_ld    = 8'h43,
        op_lbu   = 8'h44, op_lhu   = 8'h45, op_lwu   = 8'h46,
        op_sb    = 8'h60, op_sh    = 8'h61, op_sw    = 8'h62, op_sd    = 8'h63,
        op_beq   = 8'h80, op_bne   = 8'h81, op_blt   = 8'h84, op_bge   = 8'h85,
        op_bltu  = 8'h86, op_bgeu  = 8'h87,
        op_jal   = 8'ha0, op_jalr  = 8'ha1,
        op_lui   = 8'hc0, op_auipc = 8'hc1,
        op_ebreak = 8'he0
    } op_e;

    typedef union packed {
        op_e code;
        struct packed {
            unit_e      unit;
            logic [4:0] func;
        } f;
    } exu_op_u;

    typedef enum logic [1:0] {
        src_reg  = 2'd0,
        src_imm  = 2'd1,
        src_four = 2'd2
    } alu_src_e;

endpackage
